//--- tb.f
design/core_cfg_pkg.sv
design/rv_isa_pkg.sv
design/if_stage.sv
design/id_stage.sv
design/ls_stage.sv
design/sram_arbiter.sv
design/unified_sram.sv
design/frontend_top.sv
test/frontend_chk.sv
test/tb_frontend.sv

//--- test/tb_frontend.sv
// testbench for the instruction front end with program image, reference model and report checkers
`timescale 1ns/1ps

module tb_frontend;

  import core_cfg_pkg::*;
  import rv_isa_pkg::*;

  localparam int PROG_WORDS = 8;    // one word per reset cycle
  localparam int NUM_RET    = 24;   // covers several loop turns
  localparam int TIMEOUT    = 50;

  logic                    clk;
  logic                    reset;
  logic                    prog_we;
  logic [SRAM_ADDR_WD-1:0] prog_addr;
  logic [SRAM_DATA_WD-1:0] prog_data;
  logic                    ret_valid;
  retire_t                 ret;
  logic                    load_valid;
  load_res_t               load;

  logic [SRAM_DATA_WD-1:0] image [SRAM_DEPTH];
  logic [INST_WD-1:0]      code [12];
  retire_t                 exp_ret[$];
  load_res_t               exp_load[$];
  int                      ret_errs;
  int                      load_errs;
  int                      timeouts;
  int                      loads_retired;
  int                      loads_seen;

  frontend_top UUT (
    .i_clk(clk), .i_reset(reset), .i_prog_we(prog_we), .i_prog_addr(prog_addr),
    .i_prog_data(prog_data), .o_retire_valid(ret_valid), .o_retire(ret),
    .o_load_valid(load_valid), .o_load(load)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // code slots, pc = 4 * index
  task automatic build_image();
    code = '{32'h0010_0093,    // 00 addi x1, x0, 1
             32'h0020_0113,    // 04 addi x2, x0, 2
             32'h0300_3183,    // 08 ld x3, 48(x0)
             32'h0380_3203,    // 0c ld x4, 56(x0)
             32'h0000_3283,    // 10 ld x5, 0(x0), reads code
             32'h0080_006f,    // 14 jal x0, +8
             32'hfff0_0f93,    // 18 wrong path
             32'h0280_3303,    // 1c ld x6, 40(x0)
             32'h0070_0393,    // 20 addi x7, x0, 7
             32'h0300_3403,    // 24 ld x8, 48(x0)
             32'hff9f_f06f,    // 28 jal x0, -8
             32'hfff0_0f93};   // 2c wrong path
    for (int w = 0; w < 6; w++) begin
      image[w] = {code[2*w+1], code[2*w]};   // odd slot in the upper half
    end
    image[6] = {$urandom, $urandom};
    image[7] = {$urandom, $urandom};
  endtask

  function automatic logic is_abs_load(logic [INST_WD-1:0] inst);
    return (inst[6:0] == OP_LOAD) && (inst[14:12] == F3_LD) && (inst[19:15] == 5'd0);
  endfunction

  // walks the image along taken jumps
  function automatic void predict();
    logic [PC_WD-1:0]        pc;
    logic [INST_WD-1:0]      inst;
    logic [20:0]             jimm;
    logic [SRAM_ADDR_WD-1:0] waddr;
    pc = PC_RESETVAL;
    for (int n = 0; n < NUM_RET; n++) begin
      inst = pc[2] ? image[pc[10:3]][63:32] : image[pc[10:3]][31:0];
      exp_ret.push_back({pc, inst});
      waddr = inst[30:23];            // imm[10:3]
      if (is_abs_load(inst)) begin
        exp_load.push_back({waddr, image[waddr]});
      end
      if (inst[6:0] == OP_JAL) begin
        jimm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        pc   = pc + {{(PC_WD-21){jimm[20]}}, jimm};
      end else begin
        pc = pc + 32'd4;
      end
    end
  endfunction

  task automatic check_retires();
    retire_t exp;
    int      idle;
    while (exp_ret.size() > 0) begin
      idle = 0;
      do begin
        @(negedge clk);
        idle++;
      end while (!ret_valid && idle < TIMEOUT);
      if (!ret_valid) begin
        $display("no retire report for %0d cycles, %0d still expected", TIMEOUT, exp_ret.size());
        timeouts++;
        return;
      end
      exp = exp_ret.pop_front();
      assert (ret.pc == exp.pc) else begin
        $display("ERROR %0t o_retire.pc got %h expected %h", $time, ret.pc, exp.pc);
        ret_errs++;
      end
      assert (ret.inst == exp.inst) else begin
        $display("ERROR %0t o_retire.inst got %h expected %h", $time, ret.inst, exp.inst);
        ret_errs++;
      end
      if (is_abs_load(exp.inst)) begin
        loads_retired++;
      end
    end
  endtask

  task automatic check_loads();
    load_res_t exp;
    int        idle;
    while (exp_load.size() > 0) begin
      idle = 0;
      do begin
        @(negedge clk);
        idle++;
      end while (!load_valid && idle < TIMEOUT);
      if (!load_valid) begin
        $display("no load report for %0d cycles, %0d still expected", TIMEOUT, exp_load.size());
        timeouts++;
        return;
      end
      exp = exp_load.pop_front();
      assert (loads_seen < loads_retired) else begin
        $display("load report at %0t came before the retire report of its load", $time);
        load_errs++;
      end
      loads_seen++;
      assert (load.addr == exp.addr) else begin
        $display("ERROR %0t o_load.addr got %h expected %h", $time, load.addr, exp.addr);
        load_errs++;
      end
      assert (load.data == exp.data) else begin
        $display("ERROR %0t o_load.data got %h expected %h", $time, load.data, exp.data);
        load_errs++;
      end
    end
  endtask

  initial begin
    void'($urandom(32'hc82a));
    ret_errs      = 0;
    load_errs     = 0;
    timeouts      = 0;
    loads_retired = 0;
    loads_seen    = 0;
    reset         = 1'b1;
    prog_we       = 1'b0;
    prog_addr     = '0;
    prog_data     = '0;
    build_image();
    predict();
    for (int w = 0; w < PROG_WORDS; w++) begin
      prog_we   = 1'b1;
      prog_addr = SRAM_ADDR_WD'(w);
      prog_data = image[w];
      @(negedge clk);
    end
    prog_we = 1'b0;
    assert (!ret_valid && !load_valid) else begin
      $display("a report strobe was active during reset");
      ret_errs++;
    end
    reset = 1'b0;
    fork
      check_retires();
      check_loads();
    join
    $display("retire errors %0d, load errors %0d, timeouts %0d, assertion failures %0d",
             ret_errs, load_errs, timeouts, UUT.u_frontend_chk.fail_cnt);
    if (ret_errs + load_errs + timeouts + UUT.u_frontend_chk.fail_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- test/frontend_chk.sv
// concurrent checks on sram arbitration and the fetch to decode hand-off, bound into the top
`timescale 1ns/1ps

module frontend_chk (
  input logic                    i_clk,
  input logic                    i_reset,
  input logic                    i_if_gnt,
  input logic                    i_ls_gnt,
  input logic                    i_if_rvalid,
  input logic                    i_ls_rvalid,
  input logic                    i_fs_valid,
  input logic                    i_ds_allowin,
  input core_cfg_pkg::fs_to_ds_t i_fs_bus
);

  int fail_cnt = 0;

  // one owner per sram cycle
  a_one_gnt: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_if_gnt && i_ls_gnt))
    else begin
      $error("fetch and load grants high in the same cycle");
      fail_cnt++;
    end

  a_if_rsp: assert property (@(posedge i_clk) disable iff (i_reset)
    i_if_gnt |=> i_if_rvalid && !i_ls_rvalid)
    else begin
      $error("fetch grant not followed by exactly the fetch response");
      fail_cnt++;
    end

  a_ls_rsp: assert property (@(posedge i_clk) disable iff (i_reset)
    i_ls_gnt |=> i_ls_rvalid && !i_if_rvalid)
    else begin
      $error("load grant not followed by exactly the load response");
      fail_cnt++;
    end

  // held instruction and pc while decode is blocked
  a_fs_hold: assert property (@(posedge i_clk) disable iff (i_reset)
    i_fs_valid && !i_ds_allowin |=> i_fs_valid && $stable(i_fs_bus))
    else begin
      $error("stalled fetch changed its bus to decode");
      fail_cnt++;
    end

endmodule

// arbiter and fetch signals as seen from the top level wires
bind frontend_top frontend_chk u_frontend_chk (
  .i_clk(i_clk), .i_reset(i_reset), .i_if_gnt(if_gnt), .i_ls_gnt(ls_gnt),
  .i_if_rvalid(if_rvalid), .i_ls_rvalid(ls_rvalid), .i_fs_valid(fs_to_ds_valid),
  .i_ds_allowin(ds_allowin), .i_fs_bus(fs_to_ds_bus)
);

//--- design/frontend_top.sv
// front end top joining fetch, decode, load stage, arbiter and sram
`timescale 1ns/1ps

module frontend_top (
  input  logic                                  i_clk,
  input  logic                                  i_reset,
  // program port
  input  logic                                  i_prog_we,
  input  logic [core_cfg_pkg::SRAM_ADDR_WD-1:0] i_prog_addr,
  input  logic [core_cfg_pkg::SRAM_DATA_WD-1:0] i_prog_data,
  // reports
  output logic                                  o_retire_valid,
  output core_cfg_pkg::retire_t                 o_retire,
  output logic                                  o_load_valid,
  output core_cfg_pkg::load_res_t               o_load
);

  import core_cfg_pkg::*;

  logic                    ds_allowin;
  br_bus_t                 br_bus;
  logic                    fs_to_ds_valid;
  fs_to_ds_t               fs_to_ds_bus;
  logic                    ls_allowin;
  logic                    ds_to_ls_valid;
  ds_to_ls_t               ds_to_ls_bus;
  mem_req_t                if_req;
  mem_req_t                ls_req;
  mem_req_t                sram_req;
  logic                    if_gnt;
  logic                    ls_gnt;
  logic                    if_rvalid;
  logic                    ls_rvalid;
  logic [SRAM_DATA_WD-1:0] sram_rdata;
  logic [SRAM_DATA_WD-1:0] mem_rdata;

  if_stage u_if_stage (
    .i_clk(i_clk), .i_reset(i_reset), .i_ds_allowin(ds_allowin), .i_br_bus(br_bus),
    .o_fs_to_ds_valid(fs_to_ds_valid), .o_fs_to_ds_bus(fs_to_ds_bus), .o_mem_req(if_req),
    .i_mem_gnt(if_gnt), .i_mem_rvalid(if_rvalid), .i_mem_rdata(mem_rdata)
  );

  id_stage u_id_stage (
    .i_clk(i_clk), .i_reset(i_reset), .i_fs_to_ds_valid(fs_to_ds_valid),
    .i_fs_to_ds_bus(fs_to_ds_bus), .o_ds_allowin(ds_allowin), .o_br_bus(br_bus),
    .i_ls_allowin(ls_allowin), .o_ds_to_ls_valid(ds_to_ls_valid),
    .o_ds_to_ls_bus(ds_to_ls_bus), .o_retire_valid(o_retire_valid), .o_retire(o_retire)
  );

  ls_stage u_ls_stage (
    .i_clk(i_clk), .i_reset(i_reset), .i_ds_to_ls_valid(ds_to_ls_valid),
    .i_ds_to_ls_bus(ds_to_ls_bus), .o_ls_allowin(ls_allowin), .o_mem_req(ls_req),
    .i_mem_gnt(ls_gnt), .i_mem_rvalid(ls_rvalid), .i_mem_rdata(mem_rdata),
    .o_load_valid(o_load_valid), .o_load(o_load)
  );

  sram_arbiter u_sram_arbiter (
    .i_clk(i_clk), .i_reset(i_reset), .i_if_req(if_req), .i_ls_req(ls_req),
    .o_if_gnt(if_gnt), .o_ls_gnt(ls_gnt), .o_if_rvalid(if_rvalid), .o_ls_rvalid(ls_rvalid),
    .o_sram_req(sram_req), .i_sram_rdata(sram_rdata), .o_rdata(mem_rdata)
  );

  unified_sram u_unified_sram (
    .i_clk(i_clk), .i_req(sram_req), .o_rdata(sram_rdata),
    .i_prog_we(i_prog_we), .i_prog_addr(i_prog_addr), .i_prog_data(i_prog_data)
  );

endmodule

//--- design/unified_sram.sv
// synchronous 64-bit sram with one registered read port and a program write port
`timescale 1ns/1ps

module unified_sram (
  input  logic                                  i_clk,
  // read port
  input  core_cfg_pkg::mem_req_t                i_req,
  output logic [core_cfg_pkg::SRAM_DATA_WD-1:0] o_rdata,
  // program port
  input  logic                                  i_prog_we,
  input  logic [core_cfg_pkg::SRAM_ADDR_WD-1:0] i_prog_addr,
  input  logic [core_cfg_pkg::SRAM_DATA_WD-1:0] i_prog_data
);

  import core_cfg_pkg::*;

  logic [SRAM_DATA_WD-1:0] mem [SRAM_DEPTH];

  // loaded while the core sits in reset
  always_ff @(posedge i_clk) begin
    if (i_prog_we) begin
      mem[i_prog_addr] <= i_prog_data;
    end
  end

  // address sampled on the edge, data valid the next cycle
  // read of a word written on the same edge returns the old data
  always_ff @(posedge i_clk) begin
    if (i_req.ren) begin
      o_rdata <= mem[i_req.addr];
    end
  end

endmodule

//--- design/sram_arbiter.sv
// fixed-priority arbiter for the shared sram with registered response routing
`timescale 1ns/1ps

module sram_arbiter (
  input  logic                                  i_clk,
  input  logic                                  i_reset,
  // requesters
  input  core_cfg_pkg::mem_req_t                i_if_req,
  input  core_cfg_pkg::mem_req_t                i_ls_req,
  output logic                                  o_if_gnt,
  output logic                                  o_ls_gnt,
  output logic                                  o_if_rvalid,
  output logic                                  o_ls_rvalid,
  // sram side
  output core_cfg_pkg::mem_req_t                o_sram_req,
  input  logic [core_cfg_pkg::SRAM_DATA_WD-1:0] i_sram_rdata,
  output logic [core_cfg_pkg::SRAM_DATA_WD-1:0] o_rdata
);

  logic if_owner_q;    // owner of the read now on the data bus
  logic ls_owner_q;

  // load stage always wins, fetch retries
  assign o_ls_gnt = i_ls_req.ren;
  assign o_if_gnt = i_if_req.ren && !i_ls_req.ren;

  // idle cycles pass the fetch slot with ren low
  assign o_sram_req = o_ls_gnt ? i_ls_req : i_if_req;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      if_owner_q <= 1'b0;
      ls_owner_q <= 1'b0;
    end else begin
      if_owner_q <= o_if_gnt;
      ls_owner_q <= o_ls_gnt;
    end
  end

  assign o_if_rvalid = if_owner_q;
  assign o_ls_rvalid = ls_owner_q;

  // data is shared, the strobes tell who owns it
  assign o_rdata = i_sram_rdata;

endmodule

//--- design/ls_stage.sv
// one-entry load stage FSM that reads the shared sram and reports load data
`timescale 1ns/1ps

module ls_stage (
  input  logic                                  i_clk,
  input  logic                                  i_reset,
  // from decode
  input  logic                                  i_ds_to_ls_valid,
  input  core_cfg_pkg::ds_to_ls_t               i_ds_to_ls_bus,
  output logic                                  o_ls_allowin,
  // shared sram port
  output core_cfg_pkg::mem_req_t                o_mem_req,
  input  logic                                  i_mem_gnt,
  input  logic                                  i_mem_rvalid,
  input  logic [core_cfg_pkg::SRAM_DATA_WD-1:0] i_mem_rdata,
  // load report
  output logic                                  o_load_valid,
  output core_cfg_pkg::load_res_t               o_load
);

  import core_cfg_pkg::*;

  typedef enum logic [1:0] {
    LS_IDLE,
    LS_REQ,
    LS_WAIT
  } ls_state_e;

  ls_state_e               state;
  logic                    ls_accept;
  logic [SRAM_ADDR_WD-1:0] addr_q;

  assign o_load_valid   = (state == LS_WAIT) && i_mem_rvalid;
  // entry frees itself on the response cycle
  assign o_ls_allowin   = (state == LS_IDLE) || o_load_valid;
  assign ls_accept      = i_ds_to_ls_valid && o_ls_allowin;

  assign o_mem_req.ren  = state == LS_REQ;
  assign o_mem_req.addr = addr_q;

  assign o_load.addr = addr_q;
  assign o_load.data = i_mem_rdata;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state <= LS_IDLE;
    end else begin
      case (state)
        LS_IDLE: if (ls_accept) state <= LS_REQ;
        LS_REQ:  if (i_mem_gnt) state <= LS_WAIT;   // hold address until granted
        LS_WAIT: if (i_mem_rvalid) state <= ls_accept ? LS_REQ : LS_IDLE;
        default: state <= LS_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (ls_accept) begin
      addr_q <= i_ds_to_ls_bus.addr;
    end
  end

endmodule

//--- design/id_stage.sv
// decode stage with JAL target, absolute 64-bit load recognition and retire report
`timescale 1ns/1ps

module id_stage (
  input  logic                      i_clk,
  input  logic                      i_reset,
  // from fetch
  input  logic                      i_fs_to_ds_valid,
  input  core_cfg_pkg::fs_to_ds_t   i_fs_to_ds_bus,
  output logic                      o_ds_allowin,
  // redirect
  output core_cfg_pkg::br_bus_t     o_br_bus,
  // to load stage
  input  logic                      i_ls_allowin,
  output logic                      o_ds_to_ls_valid,
  output core_cfg_pkg::ds_to_ls_t   o_ds_to_ls_bus,
  // retire report
  output logic                      o_retire_valid,
  output core_cfg_pkg::retire_t     o_retire
);

  import core_cfg_pkg::*;
  import rv_isa_pkg::*;

  logic             ds_valid;
  logic             ds_first;       // first cycle of the held instruction
  logic             ds_ready_go;
  logic             ds_accept;
  fs_to_ds_t        ds_bus;
  inst_u            ds_inst;
  logic             is_jal;
  logic             is_load;
  logic [PC_WD-1:0] j_imm;

  assign ds_inst = ds_bus.inst;

  assign is_jal  = ds_inst.j.opcode == OP_JAL;
  // ld rd, imm(x0) only
  assign is_load = (ds_inst.i.opcode == OP_LOAD) &&
                   (ds_inst.i.funct3 == F3_LD) &&
                   (ds_inst.i.rs1 == 5'd0);

  // sign-extended 21-bit J immediate
  assign j_imm = {{(PC_WD-20){ds_inst.j.imm20}}, ds_inst.j.imm19_12,
                  ds_inst.j.imm11, ds_inst.j.imm10_1, 1'b0};

  assign o_br_bus.taken  = ds_valid && is_jal;
  assign o_br_bus.target = ds_bus.pc + j_imm;

  // only a load waits on the load stage
  assign ds_ready_go  = !is_load || i_ls_allowin;
  assign o_ds_allowin = !ds_valid || ds_ready_go;
  assign ds_accept    = i_fs_to_ds_valid && o_ds_allowin;

  assign o_ds_to_ls_valid    = ds_valid && is_load && ds_ready_go;
  assign o_ds_to_ls_bus.addr = ds_inst.i.imm12[10:3];

  assign o_retire_valid = ds_first;
  assign o_retire.pc    = ds_bus.pc;
  assign o_retire.inst  = ds_inst.raw;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      ds_valid <= 1'b0;
      ds_first <= 1'b0;
    end else begin
      ds_first <= ds_accept;          // one retire per instruction
      if (o_ds_allowin) begin
        ds_valid <= i_fs_to_ds_valid;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (ds_accept) begin
      ds_bus <= i_fs_to_ds_bus;
    end
  end

endmodule

//--- design/if_stage.sv
// fetch stage with pre-IF request, PC register, 32-bit half select and bus to decode
`timescale 1ns/1ps

module if_stage (
  input  logic                                  i_clk,
  input  logic                                  i_reset,
  // allowin
  input  logic                                  i_ds_allowin,
  // branch bus
  input  core_cfg_pkg::br_bus_t                 i_br_bus,
  // to decode
  output logic                                  o_fs_to_ds_valid,
  output core_cfg_pkg::fs_to_ds_t               o_fs_to_ds_bus,
  // shared sram port
  output core_cfg_pkg::mem_req_t                o_mem_req,
  input  logic                                  i_mem_gnt,
  input  logic                                  i_mem_rvalid,
  input  logic [core_cfg_pkg::SRAM_DATA_WD-1:0] i_mem_rdata
);

  import core_cfg_pkg::*;

  // pre-IF stage
  logic               pf_start;     // set on the first edge out of reset
  logic               pf_go;        // request granted and accepted into IF
  logic [PC_WD-1:0]   seq_pc;       // next PC when no redirect is pending
  logic [PC_WD-1:0]   next_pc;

  // IF stage
  logic               fs_valid;
  logic               fs_got;       // response already captured
  logic               fs_ready_go;
  logic               fs_allowin;
  logic [PC_WD-1:0]   fs_pc;
  logic [INST_WD-1:0] fs_inst_q;
  logic [INST_WD-1:0] rsp_inst;

  assign next_pc        = i_br_bus.taken ? i_br_bus.target : seq_pc;
  assign o_mem_req.ren  = pf_start && fs_allowin;
  assign o_mem_req.addr = next_pc[SRAM_ADDR_WD+2:3];
  assign pf_go          = o_mem_req.ren && i_mem_gnt;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pf_start <= 1'b0;
      seq_pc   <= PC_RESETVAL;
    end else begin
      pf_start <= 1'b1;
      if (pf_go) begin
        seq_pc <= next_pc + PC_WD'(4);
      end else if (i_br_bus.taken) begin
        seq_pc <= i_br_bus.target;    // redirect waits for the next grant
      end
    end
  end

  // response always arrives the cycle after the grant
  assign fs_ready_go      = fs_got || i_mem_rvalid;
  // a JAL in decode frees fetch and drops its wrong-path occupant
  assign fs_allowin       = !fs_valid || (fs_ready_go && (i_ds_allowin || i_br_bus.taken));
  assign o_fs_to_ds_valid = fs_valid && fs_ready_go && !i_br_bus.taken;

  // 64-bit aligned word, pc[2] picks the upper half
  assign rsp_inst = fs_pc[2] ? i_mem_rdata[SRAM_DATA_WD-1:INST_WD] : i_mem_rdata[INST_WD-1:0];

  assign o_fs_to_ds_bus.inst = fs_got ? fs_inst_q : rsp_inst;
  assign o_fs_to_ds_bus.pc   = fs_pc;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      fs_valid <= 1'b0;
      fs_got   <= 1'b0;
      fs_pc    <= PC_RESETVAL;
    end else if (fs_allowin) begin
      fs_valid <= pf_go;
      fs_got   <= 1'b0;
      if (pf_go) begin
        fs_pc <= next_pc;
      end
    end else if (i_mem_rvalid) begin
      fs_got <= 1'b1;                 // decode stalled, keep the instruction
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_mem_rvalid) begin
      fs_inst_q <= rsp_inst;
    end
  end

endmodule

//--- design/rv_isa_pkg.sv
// opcode constants and the instruction word union with J-type and I-type views
package rv_isa_pkg;

  localparam logic [6:0] OP_JAL  = 7'b110_1111;
  localparam logic [6:0] OP_LOAD = 7'b000_0011;
  localparam logic [2:0] F3_LD   = 3'b011;     // 64-bit load

  // J-type, immediate bits scattered over the upper 20 bits
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // opcode sits in the same place in every view
  typedef union packed {
    logic [31:0] raw;
    j_type_t     j;
    i_type_t     i;
  } inst_u;

endpackage

//--- design/core_cfg_pkg.sv
// core widths, reset PC, memory depth and the inter-stage bus structs
package core_cfg_pkg;

  localparam int INST_WD      = 32;
  localparam int PC_WD        = 32;
  localparam int SRAM_DATA_WD = 64;
  localparam int SRAM_DEPTH   = 256;
  localparam int SRAM_ADDR_WD = 8;    // log2 of SRAM_DEPTH

  localparam logic [PC_WD-1:0] PC_RESETVAL = 32'h0000_0000;

  // decode back to fetch, redirect on JAL
  typedef struct packed {
    logic             taken;
    logic [PC_WD-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [PC_WD-1:0]   pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic [SRAM_ADDR_WD-1:0] addr;    // 64-bit word address
  } ds_to_ls_t;

  // one request slot on the shared sram
  typedef struct packed {
    logic                    ren;
    logic [SRAM_ADDR_WD-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [PC_WD-1:0]   pc;
    logic [INST_WD-1:0] inst;
  } retire_t;

  typedef struct packed {
    logic [SRAM_ADDR_WD-1:0] addr;
    logic [SRAM_DATA_WD-1:0] data;
  } load_res_t;

endpackage
